/* include/periph_settings.svh */
// peripheral build constants: bus width, keyboard queue depth, display timing, sync depth
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// cpu-side data bus width
`define PERIPH_DATA_W 16

// scan codes held before new frames are dropped
// power of two only, the fifo full test relies on it
`define PS2_FIFO_DEPTH 4

// clk200m cycles per half period of the display shift clock
`define SEG_HALF_PERIOD 2

// flops on every asynchronous pin
// ps2 clock, ps2 data and the switch bank
`define SYNC_STAGES 2

`endif

/* verilog/ps2_pkg.sv */
// PS/2 receiver FSM state enum and data-bit counter type
package ps2_pkg;

    // frame receiver states
    // start bit is checked in idle
    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,
        RX_DATA   = 2'd1,
        RX_PARITY = 2'd2,
        RX_STOP   = 2'd3
    } ps2_state_e;

    // counts the eight data bits of a frame
    // one spare bit of headroom
    typedef logic [3:0] ps2_bitcnt_t;

    // index of the last data bit
    localparam ps2_bitcnt_t PS2_LAST_BIT = 4'd7;

endpackage

/* verilog/io_pkg.sv */
// register opcode enum, display driver FSM states and status bit positions
package io_pkg;

    // cpu register map
    // the address is the opcode
    typedef enum logic [1:0] {
        REG_KBD    = 2'd0,
        REG_SWT    = 2'd1,
        REG_SEG    = 2'd2,
        REG_STATUS = 2'd3
    } io_reg_e;

    // serial display driver states
    typedef enum logic [1:0] {
        SEG_IDLE  = 2'd0,
        SEG_SHIFT = 2'd1,
        SEG_LATCH = 2'd2
    } seg_state_e;

    // status register layout
    localparam int STAT_KB_READY = 0;
    // sticky, cleared by a status read
    localparam int STAT_KB_OVF   = 1;
    // sticky, cleared by a status read
    localparam int STAT_KB_PERR  = 2;
    localparam int STAT_SEG_BUSY = 3;

    // number of defined status bits
    localparam int STAT_BITS     = 4;

endpackage

/* verilog/ps2_kbd.sv */
// PS/2 keyboard frame receiver with odd parity check and scan-code FIFO
`timescale 1ns/1ns
`include "periph_settings.svh"

module ps2_kbd (
    input  logic       clk200m,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       kb_pop,
    output logic [7:0] kb_data,
    output logic       kb_ready,
    output logic       kb_ovf_evt,
    output logic       kb_perr_evt
);
    import ps2_pkg::*;

    localparam int PTR_W = $clog2(`PS2_FIFO_DEPTH);

    logic [`SYNC_STAGES-1:0] clk_sync;
    logic [`SYNC_STAGES-1:0] data_sync;
    logic                    clk_prev;
    logic                    ps2_fall;
    logic                    data_s;

    ps2_state_e              state;
    ps2_bitcnt_t             bit_cnt;
    logic [7:0]              frame_q;
    logic                    parity_q;
    logic                    stop_seen;
    logic                    frame_good;

    logic [7:0]              mem [`PS2_FIFO_DEPTH];
    logic [PTR_W:0]          wr_ptr;
    logic [PTR_W:0]          rd_ptr;
    logic [PTR_W:0]          fill;
    logic                    full;
    logic                    push;
    logic                    pop_ok;

    // pin synchronizers
    // reset to the idle-high level so no false edge follows reset
    always_ff @(posedge clk200m or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[`SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[`SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[`SYNC_STAGES-1];
        end
    end

    assign data_s   = data_sync[`SYNC_STAGES-1];
    // device drives data while clock is high, we sample on the fall
    assign ps2_fall = clk_prev & ~clk_sync[`SYNC_STAGES-1];

    // odd parity over data plus parity bit, stop bit must be 1
    assign stop_seen  = ps2_fall && (state == RX_STOP) && data_s;
    assign frame_good = ^{frame_q, parity_q};

    // circular fifo, extra pointer bit tells full from empty
    assign fill   = wr_ptr - rd_ptr;
    assign full   = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                    (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign push   = stop_seen && frame_good && !full;
    assign pop_ok = kb_pop && kb_ready;

    // head of queue, valid while kb_ready
    assign kb_data = mem[rd_ptr[PTR_W-1:0]];

    // frame FSM and queue control
    always_ff @(posedge clk200m or negedge arst_n) begin
        if (!arst_n) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            kb_ready    <= 1'b0;
            kb_ovf_evt  <= 1'b0;
            kb_perr_evt <= 1'b0;
        end else begin
            kb_ovf_evt  <= stop_seen && frame_good && full;
            kb_perr_evt <= stop_seen && !frame_good;
            if (ps2_fall) begin
                case (state)
                    // low start bit opens a frame
                    RX_IDLE: if (!data_s) begin
                        state   <= RX_DATA;
                        bit_cnt <= '0;
                    end
                    RX_DATA: begin
                        if (bit_cnt == PS2_LAST_BIT) begin
                            state <= RX_PARITY;
                        end
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                    RX_PARITY: state <= RX_STOP;
                    // bad stop bit drops the frame silently
                    default: state <= RX_IDLE;
                endcase
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // ready tracks occupancy without a compare on the pointers
            if (push && !pop_ok) begin
                kb_ready <= 1'b1;
            end else if (pop_ok && !push) begin
                kb_ready <= (fill != 1);
            end
        end
    end

    // shifter, parity latch and queue storage
    always_ff @(posedge clk200m) begin
        if (ps2_fall && state == RX_DATA) begin
            // lsb arrives first
            frame_q <= {data_s, frame_q[7:1]};
        end
        if (ps2_fall && state == RX_PARITY) begin
            parity_q <= data_s;
        end
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= frame_q;
        end
    end

    // write pointer never laps the read pointer
    a_ptr_order: assert property (@(posedge clk200m) disable iff (!arst_n)
        fill <= `PS2_FIFO_DEPTH);

    // registered ready flag agrees with the pointers
    a_ready_nonempty: assert property (@(posedge clk200m) disable iff (!arst_n)
        kb_ready == (wr_ptr != rd_ptr));

endmodule

/* verilog/seg_serial.sv */
// hex-to-segment encoder and serial shift-out driver for a four-digit display
`timescale 1ns/1ns
`include "periph_settings.svh"

module seg_serial (
    input  logic                      clk200m,
    input  logic                      arst_n,
    input  logic                      seg_load,
    input  logic [`PERIPH_DATA_W-1:0] seg_value,
    output logic                      seg_busy,
    output logic                      seg_sclk,
    output logic                      seg_sout,
    output logic                      seg_clrn,
    output logic                      seg_en
);
    import io_pkg::*;

    localparam int DIV_W = $clog2(`SEG_HALF_PERIOD) + 1;

    seg_state_e       state;
    logic [31:0]      shreg;
    logic [31:0]      encoded;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic             load_ok;
    logic             half_tick;
    logic             shift_step;
    logic             last_fall;

    // nibble to {dp,g,f,e,d,c,b,a}, active low, dp dark
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nib);
        logic [6:0] on;
        case (nib)
            4'h0: on = 7'h3f;
            4'h1: on = 7'h06;
            4'h2: on = 7'h5b;
            4'h3: on = 7'h4f;
            4'h4: on = 7'h66;
            4'h5: on = 7'h6d;
            4'h6: on = 7'h7d;
            4'h7: on = 7'h07;
            4'h8: on = 7'h7f;
            4'h9: on = 7'h6f;
            4'ha: on = 7'h77;
            4'hb: on = 7'h7c;
            4'hc: on = 7'h39;
            4'hd: on = 7'h5e;
            4'he: on = 7'h79;
            default: on = 7'h71;
        endcase
        return {1'b1, ~on};
    endfunction

    // leftmost digit goes out first
    assign encoded = {hex_to_seg(seg_value[15:12]), hex_to_seg(seg_value[11:8]),
                      hex_to_seg(seg_value[7:4]), hex_to_seg(seg_value[3:0])};

    // loads while busy are dropped here
    assign load_ok    = seg_load && (state == SEG_IDLE);
    assign half_tick  = (div_cnt == DIV_W'(`SEG_HALF_PERIOD - 1));
    // falling shift clock edge, next bit goes out
    assign shift_step = (state == SEG_SHIFT) && half_tick && seg_sclk && (bit_cnt != 5'd31);
    assign last_fall  = (state == SEG_SHIFT) && half_tick && seg_sclk && (bit_cnt == 5'd31);
    assign seg_busy   = (state != SEG_IDLE);

    always_ff @(posedge clk200m or negedge arst_n) begin
        if (!arst_n) begin
            state    <= SEG_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            seg_sclk <= 1'b0;
            seg_sout <= 1'b0;
            seg_en   <= 1'b0;
            seg_clrn <= 1'b0;
        end else begin
            // clear released on the first clock out of reset
            seg_clrn <= 1'b1;
            case (state)
                SEG_IDLE: if (load_ok) begin
                    state    <= SEG_SHIFT;
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                    seg_sclk <= 1'b0;
                    seg_sout <= encoded[31];
                    seg_en   <= 1'b1;
                end
                SEG_SHIFT: begin
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick) begin
                        seg_sclk <= ~seg_sclk;
                    end
                    if (shift_step) begin
                        bit_cnt  <= bit_cnt + 5'd1;
                        seg_sout <= shreg[30];
                    end
                    if (last_fall) begin
                        state    <= SEG_LATCH;
                        seg_sout <= 1'b0;
                        seg_en   <= 1'b0;
                    end
                end
                // one cycle with en low strobes the external latch
                default: state <= SEG_IDLE;
            endcase
        end
    end

    // shift register, fills with blank segments
    always_ff @(posedge clk200m) begin
        if (load_ok) begin
            shreg <= encoded;
        end else if (shift_step) begin
            shreg <= {shreg[30:0], 1'b1};
        end
    end

    // shift clock is quiet outside a transfer
    a_sclk_in_shift: assert property (@(posedge clk200m) disable iff (!arst_n)
        $changed(seg_sclk) |-> $past(state) == SEG_SHIFT);

    // a load during a transfer does not overwrite the pattern
    a_load_while_busy: assert property (@(posedge clk200m) disable iff (!arst_n)
        seg_load && seg_busy |=>
            (shreg == $past(shreg)) || (shreg == {$past(shreg[30:0]), 1'b1}));

endmodule

/* verilog/io_regs.sv */
// register decode, switch synchronizer, sticky status flags and registered read mux
`timescale 1ns/1ns
`include "periph_settings.svh"

module io_regs (
    input  logic                      clk200m,
    input  logic                      arst_n,
    input  io_pkg::io_reg_e           io_addr,
    input  logic                      io_rd,
    input  logic                      io_wr,
    input  logic [`PERIPH_DATA_W-1:0] io_wdata,
    input  logic [7:0]                swt,
    input  logic [7:0]                kb_data,
    input  logic                      kb_ready,
    input  logic                      kb_ovf_evt,
    input  logic                      kb_perr_evt,
    input  logic                      seg_busy,
    output logic [`PERIPH_DATA_W-1:0] io_rdata,
    output logic                      kb_pop,
    output logic                      seg_load,
    output logic [`PERIPH_DATA_W-1:0] seg_value
);
    import io_pkg::*;

    logic [7:0]                swt_sync [`SYNC_STAGES];
    logic                      ovf_flag;
    logic                      perr_flag;
    logic                      stat_rd;
    logic [STAT_BITS-1:0]      status;
    logic [`PERIPH_DATA_W-1:0] rdata_next;

    // strobe decode, one-cycle pulses follow the cpu strobes
    assign kb_pop    = io_rd && (io_addr == REG_KBD);
    assign seg_load  = io_wr && (io_addr == REG_SEG);
    assign seg_value = io_wdata;
    assign stat_rd   = io_rd && (io_addr == REG_STATUS);

    assign status[STAT_KB_READY] = kb_ready;
    assign status[STAT_KB_OVF]   = ovf_flag;
    assign status[STAT_KB_PERR]  = perr_flag;
    assign status[STAT_SEG_BUSY] = seg_busy;

    // read mux
    // empty queue and the write-only display register read as zero
    always_comb begin
        rdata_next = '0;
        case (io_addr)
            REG_KBD:    if (kb_ready) rdata_next[7:0] = kb_data;
            REG_SWT:    rdata_next[7:0] = swt_sync[`SYNC_STAGES-1];
            REG_STATUS: rdata_next[STAT_BITS-1:0] = status;
            default:    rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk200m or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `SYNC_STAGES; i++) begin
                swt_sync[i] <= '0;
            end
            ovf_flag  <= 1'b0;
            perr_flag <= 1'b0;
            io_rdata  <= '0;
        end else begin
            swt_sync[0] <= swt;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                swt_sync[i] <= swt_sync[i-1];
            end
            // an event in the same cycle as the clearing read wins
            if (stat_rd) begin
                ovf_flag  <= 1'b0;
                perr_flag <= 1'b0;
            end
            if (kb_ovf_evt) ovf_flag <= 1'b1;
            if (kb_perr_evt) perr_flag <= 1'b1;
            // held until the next read
            if (io_rd) io_rdata <= rdata_next;
        end
    end

    // cpu issues one access per cycle
    a_rd_wr_excl: assert property (@(posedge clk200m) disable iff (!arst_n)
        !(io_rd && io_wr));

endmodule

/* verilog/periph_top.sv */
// peripheral subsystem top: keyboard receiver, serial display driver and register block
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_top (
    input  logic                      clk200m,
    input  logic                      arst_n,
    input  io_pkg::io_reg_e           io_addr,
    input  logic                      io_rd,
    input  logic                      io_wr,
    input  logic [`PERIPH_DATA_W-1:0] io_wdata,
    input  logic                      ps2_clk,
    input  logic                      ps2_data,
    input  logic [7:0]                swt,
    output logic [`PERIPH_DATA_W-1:0] io_rdata,
    output logic                      seg_sclk,
    output logic                      seg_sout,
    output logic                      seg_clrn,
    output logic                      seg_en
);
    // keyboard to register block
    logic [7:0]                kb_data;
    logic                      kb_ready;
    logic                      kb_ovf_evt;
    logic                      kb_perr_evt;
    logic                      kb_pop;

    // register block to display
    logic                      seg_load;
    logic [`PERIPH_DATA_W-1:0] seg_value;
    logic                      seg_busy;

    ps2_kbd u_ps2_kbd (
        .clk200m     (clk200m),
        .arst_n      (arst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .kb_pop      (kb_pop),
        .kb_data     (kb_data),
        .kb_ready    (kb_ready),
        .kb_ovf_evt  (kb_ovf_evt),
        .kb_perr_evt (kb_perr_evt)
    );

    seg_serial u_seg_serial (
        .clk200m   (clk200m),
        .arst_n    (arst_n),
        .seg_load  (seg_load),
        .seg_value (seg_value),
        .seg_busy  (seg_busy),
        .seg_sclk  (seg_sclk),
        .seg_sout  (seg_sout),
        .seg_clrn  (seg_clrn),
        .seg_en    (seg_en)
    );

    io_regs u_io_regs (
        .clk200m     (clk200m),
        .arst_n      (arst_n),
        .io_addr     (io_addr),
        .io_rd       (io_rd),
        .io_wr       (io_wr),
        .io_wdata    (io_wdata),
        .swt         (swt),
        .kb_data     (kb_data),
        .kb_ready    (kb_ready),
        .kb_ovf_evt  (kb_ovf_evt),
        .kb_perr_evt (kb_perr_evt),
        .seg_busy    (seg_busy),
        .io_rdata    (io_rdata),
        .kb_pop      (kb_pop),
        .seg_load    (seg_load),
        .seg_value   (seg_value)
    );

endmodule

/* verification/tb_periph_top.sv */
// table-driven testbench for periph_top with a PS/2 frame generator and a display capture monitor
`timescale 1ns/1ns
`include "periph_settings.svh"

module tb_periph_top;
    import io_pkg::*;

    // row operations
    localparam logic [2:0] OP_FRAME    = 3'd0;
    localparam logic [2:0] OP_RFRAME   = 3'd1;
    localparam logic [2:0] OP_BADPAR   = 3'd2;
    localparam logic [2:0] OP_SWT      = 3'd3;
    localparam logic [2:0] OP_READ     = 3'd4;
    localparam logic [2:0] OP_SEG      = 3'd5;
    localparam logic [2:0] OP_SEG_PAIR = 3'd6;
    // keyboard read whose value comes from the reference queue
    localparam logic [31:0] KBD_MODEL  = 32'hffff_ffff;
    localparam int          PS2_HALF   = 20;
    localparam int          BIT_LIMIT  = 64 * `SEG_HALF_PERIOD + 64;

    typedef struct packed {
        logic [2:0]  op;
        io_reg_e     addr;
        logic [31:0] value;
        logic [31:0] expected;
    } row_t;

    logic                      clk200m;
    logic                      arst_n;
    io_reg_e                   io_addr;
    logic                      io_rd;
    logic                      io_wr;
    logic [`PERIPH_DATA_W-1:0] io_wdata;
    logic                      ps2_clk;
    logic                      ps2_data;
    logic [7:0]                swt;
    logic [`PERIPH_DATA_W-1:0] io_rdata;
    logic                      seg_sclk;
    logic                      seg_sout;
    logic                      seg_clrn;
    logic                      seg_en;

    row_t        rows[$];
    logic [7:0]  kbd_model[$];
    logic [31:0] cap_bits;
    int          cap_cnt;
    int          error_count;
    int          timeout_count;
    integer      seed;

    // lit segments a to g of each hex digit
    string seg_lit [16] = '{"abcdef", "bc", "abdeg", "abcdg", "bcfg", "acdfg", "acdefg",
                            "abc", "abcdefg", "abcdfg", "abcefg", "cdefg", "adef", "bcdeg",
                            "adefg", "aefg"};

    periph_top UUT (
        .clk200m  (clk200m),
        .arst_n   (arst_n),
        .io_addr  (io_addr),
        .io_rd    (io_rd),
        .io_wr    (io_wr),
        .io_wdata (io_wdata),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .swt      (swt),
        .io_rdata (io_rdata),
        .seg_sclk (seg_sclk),
        .seg_sout (seg_sout),
        .seg_clrn (seg_clrn),
        .seg_en   (seg_en)
    );

    initial begin
        clk200m = 1'b0;
        forever #5 clk200m = ~clk200m;
    end

    // display capture on the shift clock rise
    // sout is stable there
    always @(posedge seg_sclk) begin
        cap_bits <= {cap_bits[30:0], seg_sout};
        cap_cnt  <= cap_cnt + 1;
    end

    // active-low byte {dp,g,f,e,d,c,b,a} with dp dark
    function automatic logic [7:0] seg_byte(input logic [3:0] nib);
        string      lit;
        logic [7:0] b;
        lit = seg_lit[nib];
        b = 8'hff;
        for (int i = 0; i < lit.len(); i++) begin
            b[lit[i] - 8'h61] = 1'b0;
        end
        return b;
    endfunction

    // leftmost digit first
    function automatic logic [31:0] seg_word(input logic [15:0] v);
        return {seg_byte(v[15:12]), seg_byte(v[11:8]), seg_byte(v[7:4]), seg_byte(v[3:0])};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            error_count++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic note_timeout(input string what);
        timeout_count++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) @(posedge clk200m);
    endtask

    // one-cycle read strobe
    // data sampled mid-cycle after the register
    task automatic reg_read(input io_reg_e addr, output logic [`PERIPH_DATA_W-1:0] data);
        @(posedge clk200m);
        io_addr <= addr;
        io_rd   <= 1'b1;
        @(posedge clk200m);
        io_rd   <= 1'b0;
        @(negedge clk200m);
        data = io_rdata;
    endtask

    task automatic reg_write(input io_reg_e addr, input logic [`PERIPH_DATA_W-1:0] data);
        @(posedge clk200m);
        io_addr  <= addr;
        io_wdata <= data;
        io_wr    <= 1'b1;
        @(posedge clk200m);
        io_wr    <= 1'b0;
    endtask

    // start 0, data lsb first, odd parity, stop 1
    task automatic send_frame(input logic [7:0] b, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
        @(posedge clk200m);
        for (int i = 0; i < 11; i++) begin
            // device changes data while the clock is high
            ps2_data <= bits[i];
            hold_cycles(PS2_HALF);
            ps2_clk <= 1'b0;
            hold_cycles(PS2_HALF);
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1;
        hold_cycles(2 * PS2_HALF);
    endtask

    // reference queue drops bytes beyond the fifo depth
    task automatic queue_byte(input logic [7:0] b);
        if (kbd_model.size() < `PS2_FIFO_DEPTH) kbd_model.push_back(b);
    endtask

    // polls until REG_SWT leaves the old switch value
    task automatic set_switches(input logic [7:0] v);
        logic [`PERIPH_DATA_W-1:0] data;
        logic [7:0]                old;
        int                        guard;
        old   = swt;
        guard = 0;
        @(posedge clk200m);
        swt <= v;
        reg_read(REG_SWT, data);
        while (data[7:0] === old && guard < 16) begin
            reg_read(REG_SWT, data);
            guard++;
        end
        if (data[7:0] === old) note_timeout("switch change in REG_SWT");
    endtask

    task automatic wait_bits(input int n);
        int guard;
        guard = 0;
        while (cap_cnt < n && guard < BIT_LIMIT) begin
            @(negedge clk200m);
            guard++;
        end
        if (cap_cnt < n) note_timeout("32 captured display bits");
    endtask

    task automatic wait_display_idle();
        logic [`PERIPH_DATA_W-1:0] data;
        int                        guard;
        guard = 0;
        reg_read(REG_STATUS, data);
        while (data[STAT_SEG_BUSY] && guard < 200) begin
            reg_read(REG_STATUS, data);
            guard++;
        end
        if (data[STAT_SEG_BUSY]) note_timeout("display busy to fall");
    endtask

    // second write lands while the first transfer is busy
    task automatic run_display(input logic [15:0] first, input logic [15:0] second,
                               input logic pair, input logic [31:0] exp);
        logic [`PERIPH_DATA_W-1:0] data;
        cap_cnt = 0;
        reg_write(REG_SEG, first);
        if (pair) reg_write(REG_SEG, second);
        reg_read(REG_STATUS, data);
        check("status seg_busy", 32'd1, {31'd0, data[STAT_SEG_BUSY]});
        check("seg_en during transfer", 32'd1, {31'd0, seg_en});
        wait_bits(32);
        wait_display_idle();
        check("seg_en after transfer", 32'd0, {31'd0, seg_en});
        check("seg_sout pattern", exp, cap_bits);
        check("seg_sclk rise count", 32'd32, cap_cnt);
    endtask

    task automatic run_row(input row_t row);
        logic [`PERIPH_DATA_W-1:0] data;
        logic [31:0]               rnd;
        logic [31:0]               exp;
        logic [7:0]                head;
        case (row.op)
            OP_FRAME: begin
                send_frame(row.value[7:0], 1'b0);
                queue_byte(row.value[7:0]);
            end
            OP_RFRAME: begin
                rnd = $random(seed);
                send_frame(rnd[7:0], 1'b0);
                queue_byte(rnd[7:0]);
            end
            OP_BADPAR: send_frame(row.value[7:0], 1'b1);
            OP_SWT: set_switches(row.value[7:0]);
            OP_READ: begin
                reg_read(row.addr, data);
                exp = row.expected;
                if (row.addr == REG_KBD) begin
                    head = (kbd_model.size() > 0) ? kbd_model.pop_front() : 8'h00;
                    if (row.expected == KBD_MODEL) exp = {24'd0, head};
                end
                check($sformatf("io_rdata[addr %0d]", row.addr), exp, {16'd0, data});
            end
            OP_SEG: run_display(row.value[15:0], 16'd0, 1'b0, row.expected);
            default: run_display(row.value[15:0], row.value[31:16], 1'b1, row.expected);
        endcase
    endtask

    task automatic add_row(input logic [2:0] op, input io_reg_e addr,
                           input logic [31:0] value, input logic [31:0] expected);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.value    = value;
        r.expected = expected;
        rows.push_back(r);
    endtask

    task automatic load_table();
        // queued bytes come back in order
        // empty queue reads zero
        add_row(OP_FRAME, REG_KBD, 32'h1c, 0);
        add_row(OP_FRAME, REG_KBD, 32'h32, 0);
        add_row(OP_FRAME, REG_KBD, 32'h21, 0);
        add_row(OP_READ, REG_KBD, 0, 32'h1c);
        add_row(OP_READ, REG_KBD, 0, 32'h32);
        add_row(OP_READ, REG_KBD, 0, 32'h21);
        add_row(OP_READ, REG_KBD, 0, 32'h00);
        add_row(OP_READ, REG_STATUS, 0, 32'h0);
        // five frames into a four-entry queue
        repeat (5) add_row(OP_RFRAME, REG_KBD, 0, 0);
        add_row(OP_READ, REG_STATUS, 0, 32'h3);
        add_row(OP_READ, REG_STATUS, 0, 32'h1);
        repeat (4) add_row(OP_READ, REG_KBD, 0, KBD_MODEL);
        add_row(OP_READ, REG_KBD, 0, 32'h00);
        add_row(OP_READ, REG_STATUS, 0, 32'h0);
        // parity error drops the byte
        add_row(OP_BADPAR, REG_KBD, 32'h55, 0);
        add_row(OP_READ, REG_STATUS, 0, 32'h4);
        add_row(OP_READ, REG_KBD, 0, 32'h00);
        add_row(OP_READ, REG_STATUS, 0, 32'h0);
        add_row(OP_SWT, REG_SWT, 32'ha5, 0);
        add_row(OP_READ, REG_SWT, 0, 32'ha5);
        add_row(OP_SWT, REG_SWT, 32'h3c, 0);
        add_row(OP_READ, REG_SWT, 0, 32'h3c);
        add_row(OP_SEG, REG_SEG, 32'h1234, seg_word(16'h1234));
        add_row(OP_SEG, REG_SEG, 32'h5678, seg_word(16'h5678));
        // second value ignored while busy
        add_row(OP_SEG_PAIR, REG_SEG, 32'hffff_9abc, seg_word(16'h9abc));
        add_row(OP_SEG, REG_SEG, 32'hdef0, seg_word(16'hdef0));
        add_row(OP_READ, REG_STATUS, 0, 32'h0);
    endtask

    initial begin
        io_addr       = REG_KBD;
        io_rd         = 1'b0;
        io_wr         = 1'b0;
        io_wdata      = '0;
        ps2_clk       = 1'b1;
        ps2_data      = 1'b1;
        swt           = 8'h00;
        arst_n        = 1'b0;
        seed          = 32'h740d_dae6;
        error_count   = 0;
        timeout_count = 0;
        cap_cnt       = 0;
        cap_bits      = '0;
        @(negedge clk200m);
        check("seg_clrn in reset", 32'd0, {31'd0, seg_clrn});
        check("seg_en in reset", 32'd0, {31'd0, seg_en});
        check("seg_sclk in reset", 32'd0, {31'd0, seg_sclk});
        check("seg_sout in reset", 32'd0, {31'd0, seg_sout});
        repeat (3) @(posedge clk200m);
        arst_n <= 1'b1;
        repeat (2) @(negedge clk200m);
        check("seg_clrn after reset", 32'd1, {31'd0, seg_clrn});
        load_table();
        for (int r = 0; r < rows.size(); r++) begin
            run_row(rows[r]);
            if (timeout_count != 0) break;
        end
        $display("errors: %0d  timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+include
verilog/ps2_pkg.sv
verilog/io_pkg.sv
verilog/ps2_kbd.sv
verilog/seg_serial.sv
verilog/io_regs.sv
verilog/periph_top.sv
verification/tb_periph_top.sv
